//--- src/rv_pkg.sv
/*
 * Shared definitions for the three-stage RV32I execution pipeline
 * Widths, kept opcodes, ALU operations and operand source select
 */

package rv_pkg;

    // Datapath and register file sizes
    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;
    localparam int num_regs       = 32;
    localparam int instr_width    = 32;

    // Major opcodes still handled by the pipeline
    typedef enum logic [6:0]
    {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0]
    {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // lui just passes the upper immediate
        alu_pass_b = 4'd10
    } alu_op_e;

    // Source of an execute operand
    typedef enum logic
    {
        fwd_reg = 1'b0,
        fwd_wb  = 1'b1
    } fwd_sel_e;

endpackage

//--- src/instr_decoder.sv
/*
 * Instruction decoder
 * Splits an RV32I word into register fields, ALU control and immediate
 */

`timescale 1ns/100ps

module instr_decoder
(
    input  logic [rv_pkg::instr_width-1:0]    instr,
    output logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [rv_pkg::reg_addr_width-1:0] rd_addr,
    output rv_pkg::alu_op_e                   alu_op,
    output logic                              use_imm,
    output logic [rv_pkg::xlen-1:0]           imm,
    output logic                              rd_write
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_alt;
    logic       kept;

    // funct3 to operation, alt bit is instr[30]
    function automatic alu_op_e funct_to_op(input logic [2:0] f3, input logic alt,
                                            input logic is_reg);
        alu_op_e res;
        begin
            case (f3)
                3'b000:
                begin
                    if (alt && is_reg)
                        res = alu_sub;
                    else
                        res = alu_add;
                end
                3'b001: res = alu_sll;
                3'b010: res = alu_slt;
                3'b011: res = alu_sltu;
                3'b100: res = alu_xor;
                3'b101:
                begin
                    // sra/srai share the alt bit
                    if (alt)
                        res = alu_sra;
                    else
                        res = alu_srl;
                end
                3'b110: res = alu_or;
                default: res = alu_and;
            endcase
            return res;
        end
    endfunction

    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    always_comb
    begin
        kept    = 1'b1;
        use_imm = 1'b1;
        alu_op  = alu_add;
        // I-type immediate unless lui
        imm     = {{(xlen-12){instr[31]}}, instr[31:20]};
        case (opcode)
            op:
            begin
                use_imm = 1'b0;
                alu_op  = funct_to_op(funct3, funct7_alt, 1'b1);
            end
            op_imm:
            begin
                alu_op = funct_to_op(funct3, funct7_alt, 1'b0);
            end
            lui:
            begin
                alu_op = alu_pass_b;
                imm    = {instr[31:12], 12'b0};
            end
            default:
            begin
                kept = 1'b0;
            end
        endcase
    end

    // Unknown opcodes and rd of x0 retire with no write
    assign rd_write = kept && (rd_addr != '0);

endmodule

//--- src/register_file.sv
/*
 * Register file, 31 writable entries plus hard-wired x0
 * Reads in the write cycle see the incoming data
 */

`timescale 1ns/100ps

module register_file
(
    input  logic                              sysclk,
    input  logic                              reset,
    input  logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]           rs1_data,
    output logic [rv_pkg::xlen-1:0]           rs2_data,
    input  logic                              w_en,
    input  logic [rv_pkg::reg_addr_width-1:0] rd_addr,
    input  logic [rv_pkg::xlen-1:0]           rd_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:num_regs-1];

    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        begin
            if (addr == '0)
                return '0;
            else if (w_en && (addr == rd_addr))
                return rd_data;
            else
                return regs[addr];
        end
    endfunction

    assign rs1_data = read_port(rs1_addr);
    assign rs2_data = read_port(rs2_addr);

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            for (int i = 1; i < num_regs; i++)
                regs[i] <= '0;
        end
        else if (w_en && (rd_addr != '0))
        begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

//--- src/operand_forward.sv
/*
 * Operand forwarding for the execute stage
 * Picks the writeback result over the registered value on a match
 */

`timescale 1ns/100ps

module operand_forward
(
    input  logic [rv_pkg::reg_addr_width-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2_addr,
    input  logic [rv_pkg::xlen-1:0]           rs1_reg,
    input  logic [rv_pkg::xlen-1:0]           rs2_reg,
    input  logic                              wb_write,
    input  logic [rv_pkg::reg_addr_width-1:0] wb_rd,
    input  logic [rv_pkg::xlen-1:0]           wb_data,
    output logic [rv_pkg::xlen-1:0]           opd1,
    output logic [rv_pkg::xlen-1:0]           opd2
);
    import rv_pkg::*;

    fwd_sel_e sel1;
    fwd_sel_e sel2;

    // x0 never forwards
    function automatic fwd_sel_e pick_source(input logic [reg_addr_width-1:0] src);
        begin
            if (wb_write && (src != '0) && (src == wb_rd))
                return fwd_wb;
            else
                return fwd_reg;
        end
    endfunction

    assign sel1 = pick_source(rs1_addr);
    assign sel2 = pick_source(rs2_addr);

    always_comb
    begin
        if (sel1 == fwd_wb)
            opd1 = wb_data;
        else
            opd1 = rs1_reg;

        if (sel2 == fwd_wb)
            opd2 = wb_data;
        else
            opd2 = rs2_reg;
    end

endmodule

//--- src/alu.sv
/*
 * Integer ALU for the RV32I register and immediate operations
 */

`timescale 1ns/100ps

module alu
(
    input  logic [rv_pkg::xlen-1:0] opd1,
    input  logic [rv_pkg::xlen-1:0] opd2,
    input  rv_pkg::alu_op_e         alu_op,
    output logic [rv_pkg::xlen-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    // Only the low 5 bits shift
    assign shamt = opd2[4:0];

    always_comb
    begin
        case (alu_op)
            alu_add:
                result = opd1 + opd2;
            alu_sub:
                result = opd1 - opd2;
            alu_sll:
                result = opd1 << shamt;
            alu_slt:
                result = {{(xlen-1){1'b0}}, ($signed(opd1) < $signed(opd2))};
            alu_sltu:
                result = {{(xlen-1){1'b0}}, (opd1 < opd2)};
            alu_xor:
                result = opd1 ^ opd2;
            alu_srl:
                result = opd1 >> shamt;
            alu_sra:
                result = $unsigned($signed(opd1) >>> shamt);
            alu_or:
                result = opd1 | opd2;
            alu_and:
                result = opd1 & opd2;
            alu_pass_b:
                result = opd2;
            default:
                result = '0;
        endcase
    end

endmodule

//--- src/rv_core.sv
/*
 * Three-stage RV32I integer pipeline (decode, execute, writeback)
 * Takes instructions on a valid/ready port, reports each register write
 */

`timescale 1ns/100ps

module rv_core
(
    input  logic                              sysclk,
    input  logic                              reset,
    input  logic                              instr_valid,
    output logic                              instr_ready,
    input  logic [rv_pkg::instr_width-1:0]    instr,
    output logic                              wb_valid,
    output logic [rv_pkg::reg_addr_width-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]           wb_data
);
    import rv_pkg::*;

    logic                      accept;

    // D stage
    logic                      d_valid;
    logic [instr_width-1:0]    d_instr;
    logic [reg_addr_width-1:0] dec_rs1_addr;
    logic [reg_addr_width-1:0] dec_rs2_addr;
    logic [reg_addr_width-1:0] dec_rd_addr;
    alu_op_e                   dec_alu_op;
    logic                      dec_use_imm;
    logic [xlen-1:0]           dec_imm;
    logic                      dec_rd_write;
    logic [xlen-1:0]           rf_rs1_data;
    logic [xlen-1:0]           rf_rs2_data;

    // E stage
    logic                      e_valid;
    logic [reg_addr_width-1:0] e_rs1_addr;
    logic [reg_addr_width-1:0] e_rs2_addr;
    logic [xlen-1:0]           e_rs1_data;
    logic [xlen-1:0]           e_rs2_data;
    logic [reg_addr_width-1:0] e_rd;
    logic                      e_write;
    alu_op_e                   e_alu_op;
    logic                      e_use_imm;
    logic [xlen-1:0]           e_imm;
    logic [xlen-1:0]           fwd_opd1;
    logic [xlen-1:0]           fwd_opd2;
    logic [xlen-1:0]           alu_opd2;
    logic [xlen-1:0]           alu_result;

    // W stage
    logic                      w_valid;
    logic                      w_write;
    logic [reg_addr_width-1:0] w_rd;
    logic [xlen-1:0]           w_data;
    logic                      w_en;

    assign instr_ready = !reset;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge sysclk)
    begin
        if (reset)
        begin
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            w_valid <= 1'b0;
        end
        else
        begin
            d_valid <= accept;
            e_valid <= d_valid;
            w_valid <= e_valid;
        end
    end

    always_ff @(posedge sysclk)
    begin
        if (accept)
            d_instr <= instr;
    end

    instr_decoder decoder0
    (
        .instr    (d_instr),
        .rs1_addr (dec_rs1_addr),
        .rs2_addr (dec_rs2_addr),
        .rd_addr  (dec_rd_addr),
        .alu_op   (dec_alu_op),
        .use_imm  (dec_use_imm),
        .imm      (dec_imm),
        .rd_write (dec_rd_write)
    );

    // Write-through read covers distance two
    register_file regfile0
    (
        .sysclk   (sysclk),
        .reset    (reset),
        .rs1_addr (dec_rs1_addr),
        .rs2_addr (dec_rs2_addr),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .w_en     (w_en),
        .rd_addr  (w_rd),
        .rd_data  (w_data)
    );

    always_ff @(posedge sysclk)
    begin
        e_rs1_addr <= dec_rs1_addr;
        e_rs2_addr <= dec_rs2_addr;
        e_rs1_data <= rf_rs1_data;
        e_rs2_data <= rf_rs2_data;
        e_rd       <= dec_rd_addr;
        e_write    <= dec_rd_write;
        e_alu_op   <= dec_alu_op;
        e_use_imm  <= dec_use_imm;
        e_imm      <= dec_imm;
    end

    operand_forward forward0
    (
        .rs1_addr (e_rs1_addr),
        .rs2_addr (e_rs2_addr),
        .rs1_reg  (e_rs1_data),
        .rs2_reg  (e_rs2_data),
        .wb_write (w_en),
        .wb_rd    (w_rd),
        .wb_data  (w_data),
        .opd1     (fwd_opd1),
        .opd2     (fwd_opd2)
    );

    assign alu_opd2 = e_use_imm ? e_imm : fwd_opd2;

    alu alu0
    (
        .opd1   (fwd_opd1),
        .opd2   (alu_opd2),
        .alu_op (e_alu_op),
        .result (alu_result)
    );

    always_ff @(posedge sysclk)
    begin
        w_write <= e_write;
        w_rd    <= e_rd;
        w_data  <= alu_result;
    end

    // Register file takes the write at the end of this cycle
    assign w_en     = w_valid && w_write;
    assign wb_valid = w_en;
    assign wb_rd    = w_rd;
    assign wb_data  = w_data;

endmodule

//--- verif/wb_checker.sv
/*
 * Writeback checker for the rv_core pipeline
 * Queues each accepted write and matches it on the writeback port
 */

`timescale 1ns/100ps

module wb_checker
#(
    parameter int retire_timeout = 6
)
(
    input  logic         sysclk,
    input  logic         reset,
    input  logic         instr_valid,
    input  logic         instr_ready,
    input  logic         exp_write,
    input  logic [4:0]   exp_rd,
    input  logic [31:0]  exp_data,
    input  logic [127:0] exp_name,
    input  logic         wb_valid,
    input  logic [4:0]   wb_rd,
    input  logic [31:0]  wb_data,
    output int           value_errors,
    output int           protocol_errors,
    output int           pending
);
    // W loads on edge 3 counting acceptance as 1, seen at the following sample
    localparam int wb_latency = 3;

    int           cycle;
    logic         reset_seen;
    int           due_q[$];
    logic [4:0]   rd_q[$];
    logic [31:0]  data_q[$];
    logic [127:0] name_q[$];

    initial
    begin
        value_errors    = 0;
        protocol_errors = 0;
        pending         = 0;
        cycle           = 0;
        reset_seen      = 1'b0;
    end

    task automatic drop_front();
        begin
            void'(due_q.pop_front());
            void'(rd_q.pop_front());
            void'(data_q.pop_front());
            void'(name_q.pop_front());
        end
    endtask

    task automatic check_write();
        begin
            if (due_q.size() == 0)
            begin
                $display("Unexpected writeback to x%0d with data %h", wb_rd, wb_data);
                protocol_errors++;
            end
            else
            begin
                if (cycle != due_q[0])
                begin
                    $display("ERROR %0s: writeback edge expected %0d, actual %0d",
                             name_q[0], due_q[0], cycle);
                    protocol_errors++;
                end
                if (wb_rd !== rd_q[0])
                begin
                    $display("ERROR %0s: wb_rd expected %0d, actual %0d",
                             name_q[0], rd_q[0], wb_rd);
                    value_errors++;
                end
                if (wb_data !== data_q[0])
                begin
                    $display("ERROR %0s: wb_data expected %h, actual %h",
                             name_q[0], data_q[0], wb_data);
                    value_errors++;
                end
                drop_front();
            end
        end
    endtask

    always @(posedge sysclk)
    begin
        cycle++;
        if (reset)
        begin
            // Stage valids are only settled after the first reset edge
            if (reset_seen && (wb_valid !== 1'b0 || instr_ready !== 1'b0))
            begin
                $display("wb_valid or instr_ready was not low during reset");
                protocol_errors++;
            end
            reset_seen = 1'b1;
        end
        else
        begin
            if (instr_ready !== 1'b1)
            begin
                $display("instr_ready was not high outside reset");
                protocol_errors++;
            end
            if (wb_valid === 1'b1)
                check_write();
            else if (wb_valid !== 1'b0)
            begin
                $display("wb_valid is unknown on edge %0d", cycle);
                protocol_errors++;
            end
            else if (due_q.size() > 0 && cycle > due_q[0] + retire_timeout)
            begin
                $display("Instruction %0s was never retired", name_q[0]);
                protocol_errors++;
                drop_front();
            end
            if (instr_valid && instr_ready && exp_write)
            begin
                due_q.push_back(cycle + wb_latency);
                rd_q.push_back(exp_rd);
                data_q.push_back(exp_data);
                name_q.push_back(exp_name);
            end
        end
        pending = due_q.size();
    end

endmodule

//--- verif/tb_rv_core.sv
/*
 * Testbench for the three-stage RV32I pipeline
 * Table of instructions and expected writes, with random idle gaps
 */

`timescale 1ns/100ps

module tb_rv_core;

    localparam int ready_timeout = 20;
    localparam int drain_timeout = 20;

    typedef struct packed
    {
        logic [127:0] name;
        logic [31:0]  word;
        logic         wr;
        logic [4:0]   rd;
        logic [31:0]  data;
        logic         no_gap;
    } entry_t;

    logic         sysclk;
    logic         reset;
    logic         instr_valid;
    logic         instr_ready;
    logic [31:0]  instr;
    logic         wb_valid;
    logic [4:0]   wb_rd;
    logic [31:0]  wb_data;
    logic         exp_write;
    logic [4:0]   exp_rd;
    logic [31:0]  exp_data;
    logic [127:0] exp_name;
    int           value_errors;
    int           protocol_errors;
    int           pending;
    int           tb_errors;
    logic         aborted;
    logic         fast;
    logic [7:0]   lfsr;
    entry_t       entries[$];

    always #5 sysclk = ~sysclk;

    rv_core dut0
    (
        .sysclk      (sysclk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    wb_checker #(.retire_timeout(6)) checker0
    (
        .sysclk          (sysclk),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr_ready     (instr_ready),
        .exp_write       (exp_write),
        .exp_rd          (exp_rd),
        .exp_data        (exp_data),
        .exp_name        (exp_name),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .pending         (pending)
    );

    // alt sets instr[30], the sub and sra select
    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Galois form of x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        if (s[0])
            return (s >> 1) ^ 8'hb8;
        else
            return s >> 1;
    endfunction

    task automatic add_test(input logic [127:0] name, input logic [31:0] word,
                            input logic wr, input logic [4:0] rd, input logic [31:0] data);
        entry_t e;
        begin
            e.name   = name;
            e.word   = word;
            e.wr     = wr;
            e.rd     = rd;
            e.data   = data;
            e.no_gap = fast;
            entries.push_back(e);
        end
    endtask

    // x1 = -5 and x2 = 100 feed most later tests
    task automatic load_table();
        begin
            fast = 1'b0;
            add_test("addi_neg", enc_i(12'hffb, 5'd0, 3'd0, 5'd1), 1'b1, 5'd1, 32'hfffffffb);
            add_test("addi_pos", enc_i(12'h064, 5'd0, 3'd0, 5'd2), 1'b1, 5'd2, 32'h00000064);
            add_test("slti", enc_i(12'hffc, 5'd1, 3'd2, 5'd3), 1'b1, 5'd3, 32'h00000001);
            add_test("sltiu", enc_i(12'hfff, 5'd2, 3'd3, 5'd4), 1'b1, 5'd4, 32'h00000001);
            add_test("sltiu_big", enc_i(12'h005, 5'd1, 3'd3, 5'd5), 1'b1, 5'd5, 32'h00000000);
            add_test("xori", enc_i(12'h0f0, 5'd1, 3'd4, 5'd6), 1'b1, 5'd6, 32'hffffff0b);
            add_test("ori_neg", enc_i(12'hf00, 5'd2, 3'd6, 5'd7), 1'b1, 5'd7, 32'hffffff64);
            add_test("andi", enc_i(12'h7ff, 5'd1, 3'd7, 5'd8), 1'b1, 5'd8, 32'h000007fb);
            add_test("slli", enc_i(12'h004, 5'd2, 3'd1, 5'd9), 1'b1, 5'd9, 32'h00000640);
            add_test("srli", enc_i(12'h004, 5'd1, 3'd5, 5'd10), 1'b1, 5'd10, 32'h0fffffff);
            add_test("srai", enc_i(12'h401, 5'd1, 3'd5, 5'd11), 1'b1, 5'd11, 32'hfffffffd);
            add_test("lui", enc_u(20'h80001, 5'd12), 1'b1, 5'd12, 32'h80001000);
            add_test("add", enc_r(1'b0, 5'd2, 5'd1, 3'd0, 5'd13), 1'b1, 5'd13, 32'h0000005f);
            add_test("sub_under", enc_r(1'b1, 5'd2, 5'd1, 3'd0, 5'd14), 1'b1, 5'd14, 32'hffffff97);
            add_test("sll", enc_r(1'b0, 5'd2, 5'd1, 3'd1, 5'd15), 1'b1, 5'd15, 32'hffffffb0);
            add_test("slt", enc_r(1'b0, 5'd2, 5'd1, 3'd2, 5'd16), 1'b1, 5'd16, 32'h00000001);
            add_test("sltu", enc_r(1'b0, 5'd2, 5'd1, 3'd3, 5'd17), 1'b1, 5'd17, 32'h00000000);
            add_test("xor", enc_r(1'b0, 5'd2, 5'd1, 3'd4, 5'd18), 1'b1, 5'd18, 32'hffffff9f);
            add_test("srl", enc_r(1'b0, 5'd2, 5'd1, 3'd5, 5'd19), 1'b1, 5'd19, 32'h0fffffff);
            add_test("sra_neg", enc_r(1'b1, 5'd2, 5'd1, 3'd5, 5'd20), 1'b1, 5'd20, 32'hffffffff);
            add_test("or", enc_r(1'b0, 5'd2, 5'd1, 3'd6, 5'd21), 1'b1, 5'd21, 32'hffffffff);
            add_test("and", enc_r(1'b0, 5'd2, 5'd1, 3'd7, 5'd22), 1'b1, 5'd22, 32'h00000060);
            // Back-to-back chain, distances one to three
            fast = 1'b1;
            add_test("fwd_a0", enc_i(12'h007, 5'd0, 3'd0, 5'd23), 1'b1, 5'd23, 32'h00000007);
            add_test("fwd_a1", enc_r(1'b0, 5'd23, 5'd23, 3'd0, 5'd24), 1'b1, 5'd24, 32'h0000000e);
            add_test("fwd_a2", enc_r(1'b1, 5'd23, 5'd24, 3'd0, 5'd25), 1'b1, 5'd25, 32'h00000007);
            add_test("fwd_a3", enc_r(1'b0, 5'd23, 5'd25, 3'd0, 5'd26), 1'b1, 5'd26, 32'h0000000e);
            fast = 1'b0;
            add_test("fwd_b0", enc_i(12'h007, 5'd0, 3'd0, 5'd27), 1'b1, 5'd27, 32'h00000007);
            add_test("fwd_b1", enc_r(1'b0, 5'd27, 5'd27, 3'd0, 5'd28), 1'b1, 5'd28, 32'h0000000e);
            add_test("fwd_b2", enc_r(1'b1, 5'd27, 5'd28, 3'd0, 5'd29), 1'b1, 5'd29, 32'h00000007);
            add_test("fwd_b3", enc_r(1'b0, 5'd27, 5'd29, 3'd0, 5'd30), 1'b1, 5'd30, 32'h0000000e);
            // x1 + 12 is nonzero, so a write to x0 would show up below
            add_test("rd_x0", enc_i(12'h00c, 5'd1, 3'd0, 5'd0), 1'b0, 5'd0, 32'h00000000);
            add_test("read_x0", enc_r(1'b0, 5'd2, 5'd0, 3'd0, 5'd31), 1'b1, 5'd31, 32'h00000064);
            // sw x2, 0(x1)
            add_test("bad_opcode", 32'h0020a023, 1'b0, 5'd0, 32'h00000000);
            add_test("read_x0_imm", enc_i(12'h000, 5'd0, 3'd0, 5'd31), 1'b1, 5'd31, 32'h00000000);
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge sysclk);
            #1;
        end
    endtask

    task automatic send(input entry_t e);
        int waited;
        begin
            instr_valid = 1'b1;
            instr       = e.word;
            exp_write   = e.wr;
            exp_rd      = e.rd;
            exp_data    = e.data;
            exp_name    = e.name;
            waited      = 0;
            @(posedge sysclk);
            while (!instr_ready && waited < ready_timeout)
            begin
                waited++;
                @(posedge sysclk);
            end
            if (!instr_ready)
            begin
                $display("Timed out waiting for instr_ready on %0s", e.name);
                tb_errors++;
                aborted = 1'b1;
            end
            #1;
            instr_valid = 1'b0;
            exp_write   = 1'b0;
        end
    endtask

    initial
    begin : run
        logic [1:0] gap;
        int         waited;
        sysclk      = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        exp_write   = 1'b0;
        exp_rd      = '0;
        exp_data    = '0;
        exp_name    = '0;
        tb_errors   = 0;
        aborted     = 1'b0;
        lfsr        = 8'd24;
        load_table();
        repeat (2) @(posedge sysclk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < entries.size() && !aborted; i++)
        begin
            gap[0] = lfsr[0];
            lfsr   = lfsr_next(lfsr);
            gap[1] = lfsr[0];
            lfsr   = lfsr_next(lfsr);
            if (!entries[i].no_gap)
                idle(int'(gap));
            send(entries[i]);
        end
        waited = 0;
        while (pending != 0 && waited < drain_timeout)
        begin
            @(posedge sysclk);
            #1;
            waited++;
        end
        if (pending != 0)
        begin
            $display("Timed out with %0d writes still outstanding", pending);
            tb_errors++;
        end
        // A few quiet cycles catch stray writebacks
        idle(4);
        $display("Errors: value %0d, protocol %0d, testbench %0d",
                 value_errors, protocol_errors, tb_errors);
        if (value_errors + protocol_errors + tb_errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- list.f
src/rv_pkg.sv
src/instr_decoder.sv
src/register_file.sv
src/operand_forward.sv
src/alu.sv
src/rv_core.sv
verif/wb_checker.sv
verif/tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_rv_core -o sim_rv_core
./obj_dir/sim_rv_core | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
